// ==== src/f2_pkg.sv ====
package f2_pkg;

    ////////////////////////////////////////////////////////////
    // Widths

    typedef logic [22:0] word_addr_t;  // A23..A1, no A0 on the 68000
    typedef logic [15:0] cpu_data_t;
    typedef logic [6:0]  region_t;     // Byte address bits 23..17
    typedef logic [11:0] pix_index_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    ////////////////////////////////////////////////////////////
    // CPU bus

    typedef struct packed {
        logic       as;     // Address strobe, high during a cycle
        logic       rw;     // 1 = read
        logic [1:0] ds_n;   // Bit 1 is UDS
        logic [2:0] fc;
        word_addr_t addr;
        cpu_data_t  wdata;
    } cpu_bus_t;

    typedef struct packed {
        cpu_data_t rdata;
        logic      dtack_n;
    } cpu_resp_t;

    ////////////////////////////////////////////////////////////
    // Memory map

    localparam region_t REGION_WORK  = 7'h08;  // 0x100000
    localparam region_t REGION_COLOR = 7'h10;  // 0x200000
    localparam region_t REGION_IO    = 7'h18;  // 0x300000

    localparam int WORK_AW  = 12;
    localparam int COLOR_AW = 12;

    // CPU space cycle
    localparam logic [2:0] FC_IACK = 3'd7;

    // Interrupt levels
    localparam logic [2:0] IRQ_VBL_LEVEL = 3'd5;
    localparam logic [2:0] IRQ_DMA_LEVEL = 3'd6;

endpackage

// ==== src/f2_cpu_bus.sv ====
`timescale 1ns/1ns

module f2_cpu_bus (
    input  logic              clk,
    input  logic              reset,
    input  f2_pkg::cpu_bus_t  cpu,
    input  f2_pkg::cpu_data_t work_q,
    input  f2_pkg::cpu_data_t color_q,
    input  f2_pkg::cpu_data_t io_q,
    output f2_pkg::cpu_resp_t resp,
    output logic              work_sel,
    output logic              color_sel,
    output logic              io_sel,
    output logic              iack
);
    import f2_pkg::*;

    region_t region;
    logic    mem_access;
    logic    work_sel_q;
    logic    color_sel_q;
    logic    io_sel_q;
    logic    dtack_n;

    assign region = cpu.addr[$bits(word_addr_t)-1 -: $bits(region_t)];

    // Interrupt acknowledge, level comes on A3..A1
    assign iack = cpu.as && (cpu.fc == FC_IACK) && !cpu.ds_n[0];

    assign mem_access = cpu.as && !iack;

    ////////////////////////////////////////////////////////////
    // Chip selects

    assign work_sel  = mem_access && (region == REGION_WORK);
    assign color_sel = mem_access && (region == REGION_COLOR);
    assign io_sel    = mem_access && (region == REGION_IO);

    always_ff @(posedge clk) begin
        if (reset) begin
            work_sel_q  <= 1'b0;
            color_sel_q <= 1'b0;
            io_sel_q    <= 1'b0;
            dtack_n     <= 1'b1;
        end else begin
            work_sel_q  <= work_sel;
            color_sel_q <= color_sel;
            io_sel_q    <= io_sel;
            dtack_n     <= ~cpu.as;  // Fixed one cycle wait for every target
        end
    end

    ////////////////////////////////////////////////////////////
    // Read data

    always_comb begin
        if (work_sel_q) begin
            resp.rdata = work_q;
        end else if (color_sel_q) begin
            resp.rdata = color_q;
        end else if (io_sel_q) begin
            resp.rdata = io_q;
        end else begin
            resp.rdata = '0;  // Unmapped
        end
        resp.dtack_n = dtack_n;
    end

endmodule

// ==== src/f2_work_ram.sv ====
`timescale 1ns/1ns

module f2_work_ram (
    input  logic              clk,
    input  f2_pkg::cpu_bus_t  cpu,
    input  logic              sel,
    output f2_pkg::cpu_data_t q
);
    import f2_pkg::*;

    cpu_data_t          mem [2**WORK_AW];
    logic [WORK_AW-1:0] index;
    logic               wr;

    assign index = cpu.addr[WORK_AW-1:0];
    assign wr    = sel && !cpu.rw;

    always_ff @(posedge clk) begin
        if (wr) begin
            if (!cpu.ds_n[1]) begin
                mem[index][15:8] <= cpu.wdata[15:8];  // UDS
            end
            if (!cpu.ds_n[0]) begin
                mem[index][7:0] <= cpu.wdata[7:0];    // LDS
            end
        end
        q <= mem[index];
    end

endmodule

// ==== src/f2_io_ports.sv ====
`timescale 1ns/1ns

module f2_io_ports (
    input  logic              clk,
    input  f2_pkg::cpu_bus_t  cpu,
    input  logic              sel,
    input  logic [9:0]        joystick_p1,
    input  logic [9:0]        joystick_p2,
    input  logic [1:0]        start,
    input  logic [1:0]        coin,
    input  logic [7:0]        dswa,
    input  logic [7:0]        dswb,
    output f2_pkg::cpu_data_t q
);
    import f2_pkg::*;

    logic [7:0] dswa_r;
    logic [7:0] dswb_r;
    logic [7:0] p1_r;
    logic [7:0] p2_r;
    logic [7:0] coin_r;
    logic [7:0] port_byte;

    // Active low, same layout as the board's input chip
    always_ff @(posedge clk) begin
        dswa_r <= ~dswa;
        dswb_r <= ~dswb;
        p1_r   <= ~{start[0], joystick_p1[6:4],
                    joystick_p1[0], joystick_p1[1], joystick_p1[2], joystick_p1[3]};
        p2_r   <= ~{start[1], joystick_p2[6:4],
                    joystick_p2[0], joystick_p2[1], joystick_p2[2], joystick_p2[3]};
        coin_r <= ~{4'b0000, coin, 2'b00};
    end

    always_comb begin
        case (cpu.addr[2:0])
            3'd0:    port_byte = dswa_r;
            3'd1:    port_byte = dswb_r;
            3'd2:    port_byte = p1_r;
            3'd3:    port_byte = p2_r;
            3'd4:    port_byte = coin_r;
            default: port_byte = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        q <= sel ? {port_byte, port_byte} : '1;  // Idle bus floats high
    end

endmodule

// ==== src/f2_irq_ctrl.sv ====
`timescale 1ns/1ns

module f2_irq_ctrl (
    input  logic       clk,
    input  logic       reset,
    input  logic       vblank_n,
    input  logic       dma_n,
    input  logic       iack,
    input  logic [2:0] ack_level,
    output logic [2:0] ipl_n
);
    import f2_pkg::*;

    logic vbl_prev;
    logic dma_prev;
    logic req_vbl;
    logic req_dma;
    logic clr_vbl;
    logic clr_dma;

    assign clr_vbl = iack && (ack_level == IRQ_VBL_LEVEL);
    assign clr_dma = iack && (ack_level == IRQ_DMA_LEVEL);

    always_ff @(posedge clk) begin
        if (reset) begin
            vbl_prev <= 1'b1;
            dma_prev <= 1'b1;
            req_vbl  <= 1'b0;
            req_dma  <= 1'b0;
        end else begin
            vbl_prev <= vblank_n;
            dma_prev <= dma_n;

            if (vbl_prev && !vblank_n) begin
                req_vbl <= 1'b1;  // Start of vblank
            end
            if (!dma_prev && dma_n) begin
                req_dma <= 1'b1;  // Sprite DMA finished
            end

            // Acknowledge beats a new edge
            if (clr_vbl) begin
                req_vbl <= 1'b0;
            end
            if (clr_dma) begin
                req_dma <= 1'b0;
            end
        end
    end

    always_comb begin
        if (req_dma) begin
            ipl_n = ~IRQ_DMA_LEVEL;
        end else if (req_vbl) begin
            ipl_n = ~IRQ_VBL_LEVEL;
        end else begin
            ipl_n = 3'b111;
        end
    end

endmodule

// ==== src/f2_palette.sv ====
`timescale 1ns/1ns

module f2_palette (
    input  logic               clk,
    input  logic               reset,
    input  f2_pkg::cpu_bus_t   cpu,
    input  logic               sel,
    output f2_pkg::cpu_data_t  q,
    input  f2_pkg::pix_index_t pix,
    input  logic               ce_pixel,
    output f2_pkg::rgb_t       rgb
);
    import f2_pkg::*;

    cpu_data_t           mem [2**COLOR_AW];
    logic [COLOR_AW-1:0] cpu_index;
    cpu_data_t           pix_word;

    assign cpu_index = cpu.addr[COLOR_AW-1:0];

    ////////////////////////////////////////////////////////////
    // CPU port

    always_ff @(posedge clk) begin
        if (sel && !cpu.rw) begin
            if (!cpu.ds_n[1]) begin
                mem[cpu_index][15:8] <= cpu.wdata[15:8];
            end
            if (!cpu.ds_n[0]) begin
                mem[cpu_index][7:0] <= cpu.wdata[7:0];
            end
        end
        q <= mem[cpu_index];
    end

    ////////////////////////////////////////////////////////////
    // Pixel port

    always_ff @(posedge clk) begin
        if (reset) begin
            pix_word <= '0;
        end else if (ce_pixel) begin
            pix_word <= mem[pix];
        end
    end

    // xBBBBBGGGGGRRRRR, top bits repeated into the low end
    always_comb begin
        rgb.red   = {pix_word[4:0], pix_word[4:2]};
        rgb.green = {pix_word[9:5], pix_word[9:7]};
        rgb.blue  = {pix_word[14:10], pix_word[14:12]};
    end

endmodule

// ==== src/f2_board.sv ====
`timescale 1ns/1ns

module f2_board (
    input  logic               clk,
    input  logic               reset,
    input  f2_pkg::cpu_bus_t   cpu,
    input  logic               vblank_n,
    input  logic               dma_n,
    input  f2_pkg::pix_index_t pix,
    input  logic               ce_pixel,
    input  logic [9:0]         joystick_p1,
    input  logic [9:0]         joystick_p2,
    input  logic [1:0]         start,
    input  logic [1:0]         coin,
    input  logic [7:0]         dswa,
    input  logic [7:0]         dswb,
    output f2_pkg::cpu_resp_t  resp,
    output logic [2:0]         ipl_n,
    output f2_pkg::rgb_t       rgb
);
    import f2_pkg::*;

    cpu_data_t work_q;
    cpu_data_t color_q;
    cpu_data_t io_q;
    logic      work_sel;
    logic      color_sel;
    logic      io_sel;
    logic      iack;

    f2_cpu_bus u_cpu_bus (
        .clk       (clk),
        .reset     (reset),
        .cpu       (cpu),
        .work_q    (work_q),
        .color_q   (color_q),
        .io_q      (io_q),
        .resp      (resp),
        .work_sel  (work_sel),
        .color_sel (color_sel),
        .io_sel    (io_sel),
        .iack      (iack)
    );

    f2_work_ram u_work_ram (.clk(clk), .cpu(cpu), .sel(work_sel), .q(work_q));

    f2_io_ports u_io_ports (
        .clk(clk), .cpu(cpu), .sel(io_sel),
        .joystick_p1(joystick_p1), .joystick_p2(joystick_p2),
        .start(start), .coin(coin), .dswa(dswa), .dswb(dswb),
        .q(io_q)
    );

    f2_irq_ctrl u_irq_ctrl (
        .clk(clk), .reset(reset), .vblank_n(vblank_n), .dma_n(dma_n),
        .iack(iack), .ack_level(cpu.addr[2:0]), .ipl_n(ipl_n)
    );

    f2_palette u_palette (
        .clk(clk), .reset(reset), .cpu(cpu), .sel(color_sel), .q(color_q),
        .pix(pix), .ce_pixel(ce_pixel), .rgb(rgb)
    );

endmodule

// ==== bench/f2_board_tb.sv ====
`timescale 1ns/1ns

module f2_board_tb;
    import f2_pkg::*;

    localparam int      TIMEOUT_CYCLES = 20000;
    localparam region_t HOLES [4] = '{7'h00, 7'h09, 7'h11, 7'h7f};

    logic       clk;
    logic       reset;
    cpu_bus_t   cpu;
    cpu_resp_t  resp;
    logic       vblank_n;
    logic       dma_n;
    pix_index_t pix;
    logic       ce_pixel;
    logic [9:0] joystick_p1;
    logic [9:0] joystick_p2;
    logic [1:0] start;
    logic [1:0] coin;
    logic [7:0] dswa;
    logic [7:0] dswb;
    logic [2:0] ipl_n;
    rgb_t       rgb;

    cpu_data_t   work_shadow [4096];
    cpu_data_t   color_shadow [4096];
    logic [11:0] work_list [$];
    logic [11:0] color_list [$];
    string       name_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] act_q [$];
    int          cycles = 0;

    f2_board u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            stop_on_error("Timeout, the run did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model

    function automatic cpu_data_t merge_bytes(input cpu_data_t old, input cpu_data_t wdata,
                                              input logic [1:0] ds_n);
        cpu_data_t w;
        w = old;
        if (!ds_n[1]) begin
            w[15:8] = wdata[15:8];
        end
        if (!ds_n[0]) begin
            w[7:0] = wdata[7:0];
        end
        return w;
    endfunction

    // 5 bit field, top 3 bits repeated below it
    function automatic logic [7:0] widen5(input logic [4:0] v);
        return {v, v[4:2]};
    endfunction

    function automatic rgb_t expand_color(input cpu_data_t w);
        rgb_t c;
        c.red   = widen5(w[4:0]);
        c.green = widen5(w[9:5]);
        c.blue  = widen5(w[14:10]);
        return c;
    endfunction

    function automatic logic [7:0] player_byte(input logic start_bit, input logic [9:0] joy);
        return ~{start_bit, joy[6:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    function automatic logic [7:0] port_byte(input logic [2:0] offset);
        case (offset)
            3'd0:    return ~dswa;
            3'd1:    return ~dswb;
            3'd2:    return player_byte(start[0], joystick_p1);
            3'd3:    return player_byte(start[1], joystick_p2);
            3'd4:    return ~{4'd0, coin, 2'd0};
            default: return 8'hff;
        endcase
    endfunction

    // Level 0 gives all ones, nothing pending
    function automatic logic [2:0] ipl_for(input logic [2:0] level);
        return ~level;
    endfunction

    ////////////////////////////////////////////////////////////
    // Bus master

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic expect_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        name_q.push_back(name);
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    task automatic bus_cycle(input logic rw, input logic [2:0] fc, input logic [1:0] ds_n,
                             input word_addr_t addr, input cpu_data_t wdata,
                             output cpu_data_t rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        expect_value("dtack_n idle", 32'd1, {31'd0, resp.dtack_n});
        cpu.as    = 1'b1;
        cpu.rw    = rw;
        cpu.ds_n  = ds_n;
        cpu.fc    = fc;
        cpu.addr  = addr;
        cpu.wdata = wdata;
        do begin
            @(negedge clk);
            waited++;
            if (waited > 4) begin
                stop_on_error("No DTACK within 4 cycles of the address strobe");
            end
        end while (resp.dtack_n);
        rdata = resp.rdata;
        expect_value("dtack latency", 32'd1, waited);
        cpu.as   = 1'b0;
        cpu.ds_n = 2'b11;
    endtask

    task automatic bus_write(input word_addr_t addr, input cpu_data_t data,
                             input logic [1:0] ds_n);
        cpu_data_t unused;
        bus_cycle(1'b0, 3'b101, ds_n, addr, data, unused);
    endtask

    task automatic bus_read(input word_addr_t addr, output cpu_data_t data);
        bus_cycle(1'b1, 3'b101, 2'b00, addr, '0, data);
    endtask

    initial begin : comparator
        string       name;
        logic [31:0] exp;
        logic [31:0] act;
        forever begin
            @(posedge clk);
            while (act_q.size() > 0) begin
                name = name_q.pop_front();
                exp  = exp_q.pop_front();
                act  = act_q.pop_front();
                assert (act == exp) else begin
                    stop_on_error($sformatf("CHECK FAILED %s: expected %h, actual %h",
                                            name, exp, act));
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    initial begin : stimulus
        logic [31:0] r;
        logic [11:0] idx;
        cpu_data_t   data;
        logic [2:0]  level;
        void'($urandom(80));
        reset       = 1'b1;
        cpu         = '0;
        cpu.ds_n    = 2'b11;
        vblank_n    = 1'b1;
        dma_n       = 1'b1;
        pix         = '0;
        ce_pixel    = 1'b0;
        joystick_p1 = '0;
        joystick_p2 = '0;
        start       = '0;
        coin        = '0;
        dswa        = '0;
        dswb        = '0;
        level       = 3'd0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        expect_value("ipl_n", {29'd0, ipl_for(level)}, {29'd0, ipl_n});
        expect_value("rgb", 32'd0, {8'd0, rgb});

        // Work RAM, every fourth word also gets a single byte write
        for (int i = 0; i < 200; i++) begin
            r   = $urandom;
            idx = r[27:16];
            bus_write({REGION_WORK, 4'd0, idx}, r[15:0], 2'b00);
            work_shadow[idx] = r[15:0];
            work_list.push_back(idx);
            if (i % 4 == 0) begin
                r = $urandom;
                bus_write({REGION_WORK, 4'd0, idx}, r[15:0], {r[16], ~r[16]});
                work_shadow[idx] = merge_bytes(work_shadow[idx], r[15:0], {r[16], ~r[16]});
            end
        end
        foreach (work_list[k]) begin
            bus_read({REGION_WORK, 4'd0, work_list[k]}, data);
            expect_value("work rdata", {16'd0, work_shadow[work_list[k]]}, {16'd0, data});
        end

        repeat (3) begin
            r = $urandom;
            @(negedge clk);
            joystick_p1 = r[9:0];
            joystick_p2 = r[19:10];
            start       = r[21:20];
            coin        = r[23:22];
            dswa        = r[31:24];
            r           = $urandom;
            dswb        = r[7:0];
            for (int off = 0; off < 6; off++) begin
                bus_read({REGION_IO, 13'd0, off[2:0]}, data);
                expect_value("io rdata", {16'd0, port_byte(off[2:0]), port_byte(off[2:0])},
                             {16'd0, data});
            end
        end

        for (int i = 0; i < 256; i++) begin
            r   = $urandom;
            idx = r[27:16];
            bus_write({REGION_COLOR, 4'd0, idx}, r[15:0], 2'b00);
            color_shadow[idx] = r[15:0];
            color_list.push_back(idx);
        end
        foreach (color_list[k]) begin
            @(negedge clk);
            pix      = color_list[k];
            ce_pixel = 1'b1;
            @(negedge clk);
            ce_pixel = 1'b0;
            expect_value("rgb", {8'd0, expand_color(color_shadow[color_list[k]])}, {8'd0, rgb});
            bus_read({REGION_COLOR, 4'd0, color_list[k]}, data);
            expect_value("color rdata", {16'd0, color_shadow[color_list[k]]}, {16'd0, data});
        end

        // Holes in the map, same low bits as real RAM words
        foreach (HOLES[k]) begin
            bus_write({HOLES[k], 4'd0, work_list[0]}, 16'hdead, 2'b00);
            bus_write({HOLES[k], 4'd0, color_list[0]}, 16'hbeef, 2'b00);
            bus_read({HOLES[k], 4'd0, work_list[0]}, data);
            expect_value("unmapped rdata", 32'd0, {16'd0, data});
        end
        bus_read({REGION_WORK, 4'd0, work_list[0]}, data);
        expect_value("work rdata", {16'd0, work_shadow[work_list[0]]}, {16'd0, data});
        bus_read({REGION_COLOR, 4'd0, color_list[0]}, data);
        expect_value("color rdata", {16'd0, color_shadow[color_list[0]]}, {16'd0, data});

        ////////////////////////////////////////////////////////////
        // Interrupts

        @(negedge clk);
        vblank_n = 1'b0;
        level    = IRQ_VBL_LEVEL;
        repeat (3) @(negedge clk);
        expect_value("ipl_n", {29'd0, ipl_for(level)}, {29'd0, ipl_n});
        dma_n = 1'b0;
        repeat (2) @(negedge clk);
        dma_n = 1'b1;  // End of sprite DMA
        level = IRQ_DMA_LEVEL;
        repeat (3) @(negedge clk);
        expect_value("ipl_n", {29'd0, ipl_for(level)}, {29'd0, ipl_n});
        bus_cycle(1'b1, FC_IACK, 2'b10, {20'd0, IRQ_DMA_LEVEL}, '0, data);
        level = IRQ_VBL_LEVEL;
        @(negedge clk);
        expect_value("ipl_n", {29'd0, ipl_for(level)}, {29'd0, ipl_n});
        bus_cycle(1'b1, FC_IACK, 2'b10, {20'd0, IRQ_VBL_LEVEL}, '0, data);
        level = 3'd0;
        @(negedge clk);
        expect_value("ipl_n", {29'd0, ipl_for(level)}, {29'd0, ipl_n});
        vblank_n = 1'b1;

        repeat (2) @(negedge clk);
        if (act_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            stop_on_error("Results were left unchecked at the end of the run");
        end
    end

endmodule

// ==== f2_board.f ====
src/f2_pkg.sv
src/f2_cpu_bus.sv
src/f2_work_ram.sv
src/f2_io_ports.sv
src/f2_irq_ctrl.sv
src/f2_palette.sv
src/f2_board.sv
bench/f2_board_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module f2_board_tb -f f2_board.f -o f2_board_sim
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/f2_board_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
echo "PASS"
exit 0
